//--- hw/byte_serializer.sv
/*
 * Byte serializer
 * Takes one packet word at a time and shifts it out as 15 stream
 * bytes, most significant first, with tlast on the packet's last byte
 */
`timescale 1ns/10ps
`default_nettype none

`include "readout_defs.svh"

module byte_serializer (
	input wire clk,
	input wire reset,
	input wire readout_pkg::word_t word,
	input wire word_valid,
	input wire word_last,
	input wire tx_tready,
	output logic word_ready,
	output logic [7:0] tx_tdata,
	output logic tx_tvalid,
	output logic tx_tlast
);

	import readout_pkg::*;

	localparam int CNT_BITS = $clog2(`BYTES_PER_WORD);
	localparam logic [CNT_BITS-1:0] LAST_BYTE = CNT_BITS'(`BYTES_PER_WORD - 1);

	word_t shift_reg;
	logic [CNT_BITS-1:0] byte_cnt; // byte on the stream
	logic held; // a word is being shifted out
	logic last_flag; // word closes the packet
	logic byte_xfer;

	assign word_ready = !held;
	assign tx_tvalid = held;
	assign tx_tdata = shift_reg[`WORD_BITS-1 -: 8];
	assign tx_tlast = held && last_flag && (byte_cnt == LAST_BYTE);
	assign byte_xfer = held && tx_tready;

	// ======================================================================
	// control
	always_ff @(posedge clk) begin
		if (reset) begin
			held <= 1'b0;
			byte_cnt <= '0;
			last_flag <= 1'b0;
		end else if (!held) begin
			if (word_valid) begin
				held <= 1'b1;
				byte_cnt <= '0;
				last_flag <= word_last;
			end
		end else if (byte_xfer) begin
			byte_cnt <= byte_cnt + 1'b1;
			if (byte_cnt == LAST_BYTE)
				held <= 1'b0; // ready for the next word
		end
	end

	// ======================================================================
	// data path
	always_ff @(posedge clk) begin
		if (!held && word_valid)
			shift_reg <= word;
		else if (byte_xfer)
			shift_reg <= shift_reg << 8; // next byte to the top
	end

endmodule

`default_nettype wire

//--- hw/channel_arbiter.sv
/*
 * Channel arbiter
 * Snapshots the non-empty channels and grants them highest index first
 */
`timescale 1ns/10ps
`default_nettype none

`include "readout_defs.svh"

module channel_arbiter (
	input wire clk,
	input wire reset,
	input wire readout_pkg::chan_mask_t channel_empty,
	input wire capture,
	input wire advance,
	output readout_pkg::chan_mask_t grant,
	output logic pending
);

	import readout_pkg::*;

	chan_mask_t mask; // channels still owed a data word

	// ======================================================================
	// snapshot mask
	always_ff @(posedge clk) begin
		if (reset) begin
			mask <= '0;
		end else if (capture) begin
			mask <= ~channel_empty; // late arrivals wait for the next packet
		end else if (advance) begin
			mask <= mask & ~grant;
		end
	end

	// ======================================================================
	// priority pick, the last set bit seen wins
	always_comb begin
		grant = '0;
		for (int i = 0; i < `N_CHANNELS; i++) begin
			if (mask[i]) begin
				grant = '0;
				grant[i] = 1'b1;
			end
		end
	end

	assign pending = |mask;

endmodule

`default_nettype wire

//--- hw/frame_builder.sv
/*
 * Frame builder
 * Walks header, data and tail words for one packet and pops the
 * granted channel FIFO on each data word transfer
 */
`timescale 1ns/10ps
`default_nettype none

`include "readout_defs.svh"

module frame_builder (
	input wire clk,
	input wire reset,
	input wire frame_start,
	input wire [`MAC_BITS-1:0] d_mac,
	input wire [`MAC_BITS-1:0] s_mac,
	input wire readout_pkg::chan_mask_t grant,
	input wire pending,
	input wire [`N_CHANNELS-1:0][`PAYLOAD_BITS-1:0] channel_data,
	input wire [`N_CHANNELS-1:0][`COUNT_BITS-1:0] channel_count,
	input wire word_ready,
	output logic capture,
	output logic advance,
	output readout_pkg::chan_mask_t channel_read,
	output readout_pkg::word_t word,
	output logic word_valid,
	output logic word_last
);

	import readout_pkg::*;

	builder_state_e state;
	word_kind_e kind;
	logic [7:0] packet_count;
	logic [`CHAN_ID_BITS-1:0] grant_id;
	logic word_xfer;
	word_t tail_live;
	word_t tail_hold; // counts frozen while the tail waits

	assign word_valid = (state == state_header) || (state == state_data) || (state == state_tail);
	assign word_xfer = word_valid && word_ready;
	assign capture = (state == state_idle) && frame_start; // arbiter loads by next cycle

	// ======================================================================
	// word formatting
	always_comb begin
		grant_id = '0;
		for (int i = 0; i < `N_CHANNELS; i++) begin
			if (grant[i])
				grant_id = `CHAN_ID_BITS'(i);
		end
	end

	assign tail_live = {channel_count, {`TAIL_FILL_BITS{1'b1}}}; // channel 7 leads

	always_comb begin
		case (state)
			state_header: kind = kind_header;
			state_data: kind = pending ? kind_data : kind_tail;
			default: kind = kind_tail;
		endcase
	end

	always_comb begin
		case (kind)
			kind_header: word = {d_mac, s_mac, packet_count, `HEADER_TRAILER};
			kind_data: word = {1'b1, grant_id, channel_data[grant_id]}; // marker, id, payload
			default: word = (state == state_tail) ? tail_hold : tail_live;
		endcase
	end

	assign word_last = (kind == kind_tail);

	// pop and advance together on a data word transfer
	assign advance = word_xfer && (kind == kind_data);
	assign channel_read = advance ? grant : '0;

	// ======================================================================
	// FSM and packet count
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= state_idle;
			packet_count <= '0;
		end else begin
			case (state)
				state_idle: begin
					if (frame_start)
						state <= state_capture;
				end
				state_capture: begin
					state <= pending ? state_header : state_idle; // nothing to send
				end
				state_header: begin
					if (word_xfer) begin
						state <= state_data;
						packet_count <= packet_count + 8'd1; // wraps at 256
					end
				end
				state_data: begin
					if (!pending)
						state <= word_xfer ? state_idle : state_tail;
				end
				state_tail: begin
					if (word_xfer)
						state <= state_idle;
				end
				default: state <= state_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == state_data) && !pending)
			tail_hold <= tail_live; // first cycle the tail is on offer
	end

endmodule

`default_nettype wire

//--- hw/frame_timer.sv
/*
 * Frame timer
 * Free-running period counter, pulses a readout request at mid-period
 */
`timescale 1ns/10ps
`default_nettype none

`include "readout_defs.svh"

module frame_timer (
	input wire clk,
	input wire reset,
	input wire [`TIMER_BITS-1:0] counter_th,
	output logic frame_start
);

	logic [`TIMER_BITS-1:0] count;
	logic [`TIMER_BITS-1:0] next_count;
	logic [`TIMER_BITS-1:0] mid_point;

	assign mid_point = counter_th >> 1;
	assign next_count = (count == counter_th) ? '0 : count + 1'b1; // wraps after the threshold

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			frame_start <= 1'b0;
		end else begin
			count <= next_count;
			// registered, so compare the value the counter is about to take
			frame_start <= (next_count == mid_point);
		end
	end

endmodule

`default_nettype wire

//--- hw/readout_control.sv
/*
 * Readout control top level
 * Periodic snapshot of eight channel FIFOs, packed into one packet
 * of header, data and tail words and streamed out bytewise
 */
`timescale 1ns/10ps
`default_nettype none

`include "readout_defs.svh"

module readout_control (
	input wire clk,
	input wire reset,
	input wire [`MAC_BITS-1:0] d_mac,
	input wire [`MAC_BITS-1:0] s_mac,
	input wire [`TIMER_BITS-1:0] counter_th,
	input wire readout_pkg::chan_mask_t channel_empty,
	input wire [`N_CHANNELS-1:0][`PAYLOAD_BITS-1:0] channel_data,
	input wire [`N_CHANNELS-1:0][`COUNT_BITS-1:0] channel_count,
	output readout_pkg::chan_mask_t channel_read,
	output logic [7:0] tx_tdata,
	output logic tx_tvalid,
	output logic tx_tlast,
	input wire tx_tready
);

	import readout_pkg::*;

	logic frame_start;
	logic capture;
	logic advance;
	chan_mask_t grant;
	logic pending;
	word_t word;
	logic word_valid;
	logic word_last;
	logic word_ready;

	frame_timer u_frame_timer (
		.clk         (clk),
		.reset       (reset),
		.counter_th  (counter_th),
		.frame_start (frame_start)
	);

	// decode
	channel_arbiter u_channel_arbiter (
		.clk           (clk),
		.reset         (reset),
		.channel_empty (channel_empty),
		.capture       (capture),
		.advance       (advance),
		.grant         (grant),
		.pending       (pending)
	);

	// execute
	frame_builder u_frame_builder (
		.clk           (clk),
		.reset         (reset),
		.frame_start   (frame_start),
		.d_mac         (d_mac),
		.s_mac         (s_mac),
		.grant         (grant),
		.pending       (pending),
		.channel_data  (channel_data),
		.channel_count (channel_count),
		.word_ready    (word_ready),
		.capture       (capture),
		.advance       (advance),
		.channel_read  (channel_read),
		.word          (word),
		.word_valid    (word_valid),
		.word_last     (word_last)
	);

	// result
	byte_serializer u_byte_serializer (
		.clk        (clk),
		.reset      (reset),
		.word       (word),
		.word_valid (word_valid),
		.word_last  (word_last),
		.tx_tready  (tx_tready),
		.word_ready (word_ready),
		.tx_tdata   (tx_tdata),
		.tx_tvalid  (tx_tvalid),
		.tx_tlast   (tx_tlast)
	);

endmodule

`default_nettype wire

//--- hw/readout_pkg.sv
/*
 * Readout packetizer types
 * Channel masks, packet words, builder states and word kinds
 */
`default_nettype none

package readout_pkg;

	`include "readout_defs.svh"

	typedef logic [`N_CHANNELS-1:0] chan_mask_t; // one bit per channel
	typedef logic [`WORD_BITS-1:0] word_t; // one packet word

	// builder FSM
	typedef enum logic [2:0] {
		state_idle,
		state_capture, // snapshot taken, checking pending
		state_header,
		state_data, // data words, tail once the mask runs dry
		state_tail // tail held under back-pressure
	} builder_state_e;

	// format of the word on offer
	typedef enum logic [1:0] {
		kind_header,
		kind_data,
		kind_tail
	} word_kind_e;

endpackage

`default_nettype wire

//--- include/readout_defs.svh
/*
 * Readout packetizer constants
 * Channel count, word layout and stream widths shared by the RTL
 */
`ifndef READOUT_DEFS_SVH
`define READOUT_DEFS_SVH

// ======================================================================
// channel side
`define N_CHANNELS      8
`define CHAN_ID_BITS    3
`define PAYLOAD_BITS    116
`define COUNT_BITS      10

// ======================================================================
// packet and stream side
`define WORD_BITS       120
`define TIMER_BITS      12
`define MAC_BITS        48
`define BYTES_PER_WORD  15
`define HEADER_TRAILER  16'h00ff
`define TAIL_FILL_BITS  40

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the readout packetizer testbench with Verilator and runs it.
# The run passes only if the simulation prints the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
	--top-module tb_readout_control -o tb_readout_control \
	&& ./obj_dir/tb_readout_control | tee /dev/stderr | grep -qx "No errors" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- sim/tb_readout_control.sv
/*
 * Testbench for the readout packetizer
 * Models the eight channel FIFOs and predicts every stream byte
 */
`timescale 1ns/10ps
`default_nettype none

`include "readout_defs.svh"

module tb_readout_control;

	localparam int COUNTER_TH = 40;
	localparam int PERIOD_CYCLES = COUNTER_TH + 1;
	localparam int TEST_PERIODS = 40; // 4 + 3 + 5 + 20 + 8
	localparam int WATCHDOG_NS = 2 * TEST_PERIODS * PERIOD_CYCLES * 100;

	logic clk;
	logic reset;
	logic [`MAC_BITS-1:0] d_mac;
	logic [`MAC_BITS-1:0] s_mac;
	logic [`TIMER_BITS-1:0] counter_th;
	logic [`N_CHANNELS-1:0] channel_empty;
	logic [`N_CHANNELS-1:0][`PAYLOAD_BITS-1:0] channel_data;
	logic [`N_CHANNELS-1:0][`COUNT_BITS-1:0] channel_count;
	logic [`N_CHANNELS-1:0] channel_read;
	logic [7:0] tx_tdata;
	logic tx_tvalid;
	logic tx_tlast;
	logic tx_tready;

	logic [`PAYLOAD_BITS-1:0] fifo_q [`N_CHANNELS][$]; // first word falls through
	logic [7:0] exp_bytes [$];
	int read_count [`N_CHANNELS];
	int errors;
	int checks;
	int packets;
	int bytes_seen;
	int rx_idx;
	int tail_at; // byte index where the tail word starts
	int last_len;
	int cycle_count;
	int start_cycle; // cycle of the latest packet's first tvalid
	logic in_packet;
	logic rand_ready;
	logic stall_prev;
	logic [7:0] hold_data;
	logic hold_last;
	logic [7:0] exp_pkt_count;
	integer seed;

	readout_control UUT (
		.clk           (clk),
		.reset         (reset),
		.d_mac         (d_mac),
		.s_mac         (s_mac),
		.counter_th    (counter_th),
		.channel_empty (channel_empty),
		.channel_data  (channel_data),
		.channel_count (channel_count),
		.channel_read  (channel_read),
		.tx_tdata      (tx_tdata),
		.tx_tvalid     (tx_tvalid),
		.tx_tlast      (tx_tlast),
		.tx_tready     (tx_tready)
	);

	always #50 clk = ~clk;

	// ======================================================================
	// channel FIFO models and reference packet
	function automatic void drive_channels();
		for (int i = 0; i < `N_CHANNELS; i++) begin
			channel_empty[i] = (fifo_q[i].size() == 0);
			channel_data[i] = (fifo_q[i].size() != 0) ? fifo_q[i][0] : '0;
			channel_count[i] = `COUNT_BITS'(fifo_q[i].size());
		end
	endfunction

	function automatic void push_word(input int ch, input logic [`PAYLOAD_BITS-1:0] p);
		fifo_q[ch].push_back(p);
		drive_channels();
	endfunction

	function automatic logic [`PAYLOAD_BITS-1:0] rand_payload();
		logic [127:0] r;
		r = {$random(seed), $random(seed), $random(seed), $random(seed)};
		return r[`PAYLOAD_BITS-1:0];
	endfunction

	function automatic void append_word(input logic [`WORD_BITS-1:0] w);
		for (int b = 0; b < `BYTES_PER_WORD; b++)
			exp_bytes.push_back(w[`WORD_BITS-1-8*b -: 8]); // msb first
	endfunction

	function automatic void predict_packet();
		exp_bytes.delete();
		append_word({d_mac, s_mac, exp_pkt_count, 8'h00, 8'hff});
		for (int i = `N_CHANNELS-1; i >= 0; i--) begin
			if (fifo_q[i].size() != 0)
				append_word({1'b1, 3'(i), fifo_q[i][0]}); // marker, id, payload
		end
		tail_at = exp_bytes.size();
		exp_pkt_count = exp_pkt_count + 8'd1;
	endfunction

	// counts as they stand once every snapshot channel has been popped
	function automatic logic [`WORD_BITS-1:0] predict_tail();
		logic [`WORD_BITS-1:0] w;
		w = '1;
		for (int i = 0; i < `N_CHANNELS; i++)
			w[`TAIL_FILL_BITS + `COUNT_BITS*i +: `COUNT_BITS] = `COUNT_BITS'(fifo_q[i].size());
		return w;
	endfunction

	function automatic int queued_total();
		int n;
		n = 0;
		for (int i = 0; i < `N_CHANNELS; i++)
			n += fifo_q[i].size();
		return n;
	endfunction

	// ======================================================================
	// stream monitor and FIFO pops, sampled on the rising edge
	always @(posedge clk) begin
		if (reset) begin
			stall_prev = 1'b0;
		end else begin
			cycle_count++;
			if (stall_prev) begin
				checks++;
				assert (tx_tvalid && tx_tdata == hold_data && tx_tlast == hold_last) else begin
					$display("[FAIL] tx_tdata/tx_tlast under stall: got %h/%h expected %h/%h",
						tx_tdata, tx_tlast, hold_data, hold_last);
					errors++;
				end
			end
			if (tx_tvalid && !in_packet) begin
				in_packet = 1'b1;
				rx_idx = 0;
				start_cycle = cycle_count;
				predict_packet();
				if (tail_at == `BYTES_PER_WORD) begin
					$display("a packet started while every modeled channel was empty");
					errors++;
				end
			end
			if (tx_tvalid && tx_tready) begin
				if (rx_idx == tail_at)
					append_word(predict_tail());
				if (rx_idx < exp_bytes.size()) begin
					checks += 2;
					assert (tx_tdata == exp_bytes[rx_idx]) else begin
						$display("[FAIL] tx_tdata byte %0d: got %h expected %h",
							rx_idx, tx_tdata, exp_bytes[rx_idx]);
						errors++;
					end
					assert (tx_tlast == (rx_idx == tail_at + `BYTES_PER_WORD - 1)) else begin
						$display("[FAIL] tx_tlast byte %0d: got %h expected %h",
							rx_idx, tx_tlast, !tx_tlast);
						errors++;
					end
				end else begin
					$display("byte %0d arrived past the end of the expected packet", rx_idx);
					errors++;
				end
				rx_idx++;
				bytes_seen++;
				if (tx_tlast) begin
					in_packet = 1'b0;
					packets++;
					last_len = rx_idx;
				end
			end
			for (int i = 0; i < `N_CHANNELS; i++) begin
				if (channel_read[i]) begin
					read_count[i]++;
					assert (fifo_q[i].size() != 0) else begin
						$display("channel %0d was read while its FIFO was empty", i);
						errors++;
					end
					if (fifo_q[i].size() != 0)
						void'(fifo_q[i].pop_front());
				end
			end
			stall_prev = tx_tvalid && !tx_tready;
			hold_data = tx_tdata;
			hold_last = tx_tlast;
		end
	end

	// inputs change on the falling edge only
	always @(negedge clk) begin
		if (rand_ready)
			tx_tready = 1'($random(seed));
		drive_channels();
	end

	// ======================================================================
	// helpers
	task automatic wait_packets(input int target);
		while (packets < target)
			@(negedge clk);
	endtask

	task automatic wait_in_packet();
		while (!in_packet)
			@(negedge clk);
	endtask

	function automatic void check_value(input string name, input int got, input int expected);
		checks++;
		assert (got == expected) else begin
			$display("[FAIL] %s: got %h expected %h", name, got, expected);
			errors++;
		end
	endfunction

	task automatic report_test(input string name, input int err_start);
		$display("test %s: %s (%0d errors)", name,
			(errors == err_start) ? "ok" : "failed", errors - err_start);
	endtask

	// ======================================================================
	// stimulus
	initial begin
		int err_start;
		int base;
		int rd_base;
		int n;
		int max_n;
		int first_start;
		clk = 1'b0;
		reset = 1'b1;
		d_mac = 48'h0a1b2c3d4e5f;
		s_mac = 48'h665544332211;
		counter_th = `TIMER_BITS'(COUNTER_TH);
		tx_tready = 1'b1;
		rand_ready = 1'b0;
		in_packet = 1'b0;
		stall_prev = 1'b0;
		hold_data = '0;
		hold_last = 1'b0;
		errors = 0;
		checks = 0;
		packets = 0;
		bytes_seen = 0;
		rx_idx = 0;
		tail_at = 0;
		last_len = 0;
		cycle_count = 0;
		start_cycle = 0;
		exp_pkt_count = '0;
		seed = 32'h2c9d;
		for (int i = 0; i < `N_CHANNELS; i++)
			read_count[i] = 0;
		drive_channels();
		repeat (5) @(negedge clk);
		reset = 1'b0;

		// idle, nothing queued
		err_start = errors;
		check_value("tx_tvalid after reset", int'(tx_tvalid), 0);
		check_value("tx_tlast after reset", int'(tx_tlast), 0);
		check_value("channel_read after reset", int'(channel_read), 0);
		repeat (3 * PERIOD_CYCLES) @(negedge clk);
		check_value("bytes on tx_tdata while idle", bytes_seen, 0);
		report_test("1 idle", err_start);

		// one channel, one packet
		err_start = errors;
		push_word(5, rand_payload());
		wait_packets(1);
		check_value("packet length", last_len, 3 * `BYTES_PER_WORD);
		check_value("channel_read[5] pulses", read_count[5], 1);
		report_test("2 single channel", err_start);

		// descending order, late fill waits a packet
		err_start = errors;
		base = packets;
		push_word(1, rand_payload());
		push_word(4, rand_payload());
		push_word(6, rand_payload());
		wait_in_packet();
		push_word(3, rand_payload()); // after the snapshot
		wait_packets(base + 1);
		check_value("channel_read[1] pulses", read_count[1], 1);
		check_value("channel_read[4] pulses", read_count[4], 1);
		check_value("channel_read[6] pulses", read_count[6], 1);
		check_value("channel_read[3] pulses", read_count[3], 0);
		wait_packets(base + 2);
		check_value("channel_read[3] pulses", read_count[3], 1);
		report_test("3 channel order", err_start);

		// random back-pressure
		err_start = errors;
		base = packets;
		max_n = 0;
		rand_ready = 1'b1;
		for (int i = 0; i < `N_CHANNELS; i++) begin
			n = ($random(seed) & 1) + 1;
			if (n > max_n)
				max_n = n;
			for (int k = 0; k < n; k++)
				push_word(i, rand_payload());
		end
		while (queued_total() != 0 || in_packet)
			@(negedge clk);
		rand_ready = 1'b0;
		tx_tready = 1'b1;
		check_value("packets under back-pressure", packets - base, max_n);
		report_test("4 random tready", err_start);

		// request skipped while a packet is stalled
		err_start = errors;
		base = packets;
		rd_base = read_count[2];
		tx_tready = 1'b0;
		push_word(2, rand_payload());
		push_word(2, rand_payload());
		wait_in_packet();
		first_start = start_cycle;
		// stalled past one request, released so the packet ends clear of the next
		repeat (PERIOD_CYCLES + 10) @(negedge clk);
		tx_tready = 1'b1;
		wait_packets(base + 1);
		check_value("channel_read[2] pulses", read_count[2] - rd_base, 1);
		check_value("channel 2 FIFO level", fifo_q[2].size(), 1);
		wait_packets(base + 2);
		check_value("channel_read[2] pulses", read_count[2] - rd_base, 2);
		// a fresh request starts the second packet, so both share the frame phase
		check_value("packet start offset within the period",
			(start_cycle - first_start) % PERIOD_CYCLES, 0);
		report_test("5 packet count and skip", err_start);

		$display("tests 5, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests completed");
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
hw/readout_pkg.sv
hw/frame_timer.sv
hw/channel_arbiter.sv
hw/frame_builder.sv
hw/byte_serializer.sv
hw/readout_control.sv
sim/tb_readout_control.sv
